/* crossbar.sv */
`include "router_defines.svh"

module crossbar (
  input  logic                  clk,
  input  logic                  rst,
  flitLink.tap                  heads [`NUM_PORTS],
  input  logic [`NUM_PORTS-1:0] pops,
  input  logic [`NUM_PORTS:0]   grants [`NUM_PORTS],
  output logic [`FLIT_ID_W-1:0] outFlitId [`NUM_PORTS],
  output logic [`PAYLOAD_W-1:0] outPayload [`NUM_PORTS],
  output logic [`NUM_PORTS-1:0] outValid
);

  logic [`FLIT_ID_W-1:0] headId [`NUM_PORTS];
  logic [`PAYLOAD_W-1:0] headData [`NUM_PORTS];
  logic [`FLIT_ID_W-1:0] selId [`NUM_PORTS];
  logic [`PAYLOAD_W-1:0] selData [`NUM_PORTS];
  logic [`NUM_PORTS-1:0] selValid;
  logic [`FLIT_ID_W-1:0] stageId [`NUM_PORTS];
  logic [`PAYLOAD_W-1:0] stageData [`NUM_PORTS];
  logic [`NUM_PORTS-1:0] stageValid;
  logic [`NUM_PORTS-1:0] grantedBy [`NUM_PORTS];

  for (genvar i = 0; i < `NUM_PORTS; i++)
  begin : headGen
    assign headId[i] = heads[i].flitId;
    assign headData[i] = heads[i].payload.data;
    for (genvar o = 0; o < `NUM_PORTS; o++)
    begin : grantGen
      assign grantedBy[i][o] = grants[o][i + 1];
    end

    // An input feeds at most one output at a time.
    singleOutput: assert property (@(posedge clk) disable iff (rst)
      $onehot0(grantedBy[i]))
      else $error("crossbar: input %0d granted by two outputs", i);
  end

  always_comb
  begin
    for (int o = 0; o < `NUM_PORTS; o++)
    begin
      selValid[o] = 1'b0;
      selId[o] = '0;
      selData[o] = '0;
      for (int i = 0; i < `NUM_PORTS; i++)
      begin
        if (grants[o][i + 1] && pops[i])
        begin
          selValid[o] = 1'b1;
          selId[o] = headId[i];
          selData[o] = headData[i];
        end
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      stageValid <= '0;
      outValid <= '0;
    end
    else
    begin
      stageValid <= selValid; // Switch stage.
      outValid <= stageValid; // Output stage.
    end
  end

  always_ff @(posedge clk)
  begin
    stageId <= selId;
    stageData <= selData;
    outFlitId <= stageId;
    outPayload <= stageData;
  end

endmodule

/* flitFifo.sv */
`include "router_defines.svh"

module flitFifo (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`FLIT_ID_W-1:0] inFlitId,
  input  routerPkg::flitPayload inPayload,
  input  logic                  inValid,
  flitLink.fifo                 head
);

  localparam int ptrW = $clog2(`FIFO_DEPTH);
  localparam logic [ptrW-1:0] lastIdx = ptrW'(`FIFO_DEPTH - 1);
  localparam logic [ptrW:0] depth = (ptrW + 1)'(`FIFO_DEPTH);

  logic [`FLIT_ID_W-1:0] idMem [`FIFO_DEPTH];
  routerPkg::flitPayload dataMem [`FIFO_DEPTH];
  logic [ptrW-1:0] wrPtr;
  logic [ptrW-1:0] rdPtr;
  logic [ptrW:0] fill;
  logic full;
  logic wrEn;
  logic rdEn;

  assign full = (fill == depth);
  assign rdEn = head.pop && head.notEmpty;
  assign wrEn = inValid && (!full || rdEn); // Slot freed by a same-cycle pop.

  assign head.notEmpty = (fill != '0);
  assign head.flitId = head.notEmpty ? idMem[rdPtr] : '0; // Empty shows no flit.
  assign head.payload = dataMem[rdPtr];

  always_ff @(posedge clk)
  begin
    if (wrEn)
    begin
      idMem[wrPtr] <= inFlitId;
      dataMem[wrPtr] <= inPayload;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      fill <= '0;
    end
    else
    begin
      if (wrEn)
        wrPtr <= (wrPtr == lastIdx) ? '0 : wrPtr + 1'b1;
      if (rdEn)
        rdPtr <= (rdPtr == lastIdx) ? '0 : rdPtr + 1'b1;
      case ({wrEn, rdEn})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
    end
  end

  // The source must keep within FIFO_DEPTH unpopped flits.
  noOverflow: assert property (@(posedge clk) disable iff (rst)
    inValid |-> (!full || rdEn))
    else $error("flitFifo: write while full");

endmodule

/* flitLink.sv */
`include "router_defines.svh"

interface flitLink;
  logic [`FLIT_ID_W-1:0] flitId;
  routerPkg::flitPayload payload;
  logic notEmpty;
  logic pop;

  modport fifo (
    output flitId, payload, notEmpty,
    input  pop
  );

  modport route (
    input  flitId, payload, notEmpty,
    output pop
  );

  modport tap (
    input flitId, payload
  );
endinterface

/* inputRoute.sv */
`include "router_defines.svh"

module inputRoute #(
  parameter int routerX = 0,
  parameter int routerY = 0,
  parameter routerPkg::portIdx myPort = routerPkg::portLocal
) (
  input  logic                   clk,
  input  logic                   rst,
  flitLink.route                 head,
  input  logic [`NUM_PORTS:0]    grants [`NUM_PORTS],
  output logic [`NUM_PORTS-1:0]  req
);

  localparam logic [`COORD_W-1:0] hereX = `COORD_W'(routerX);
  localparam logic [`COORD_W-1:0] hereY = `COORD_W'(routerY);

  routerPkg::headerFields hdr;
  routerPkg::portIdx newRoute;
  routerPkg::portIdx heldRoute;
  routerPkg::portIdx curRoute;
  logic busy; // Inside a packet, after its header popped.
  logic [`LENGTH_W-1:0] remaining;
  logic [`NUM_PORTS-1:0] mine;
  logic isHeader;
  logic isBody;

  assign hdr = head.payload.header;
  assign isHeader = head.notEmpty && (head.flitId == `FLIT_HEADER);
  assign isBody = head.notEmpty && (head.flitId == `FLIT_BODY);

  // XY routing, X first.
  always_comb
  begin
    if (hdr.destX > hereX)
      newRoute = routerPkg::portEast;
    else if (hdr.destX < hereX)
      newRoute = routerPkg::portWest;
    else if (hdr.destY > hereY)
      newRoute = routerPkg::portNorth;
    else if (hdr.destY < hereY)
      newRoute = routerPkg::portSouth;
    else
      newRoute = routerPkg::portLocal;
  end

  assign curRoute = busy ? heldRoute : newRoute;

  always_comb
  begin
    req = '0;
    if (busy ? isBody : isHeader)
      req[curRoute] = 1'b1; // Drops while the source stalls.
  end

  for (genvar o = 0; o < `NUM_PORTS; o++)
  begin : grantGen
    assign mine[o] = grants[o][int'(myPort) + 1];
  end

  assign head.pop = |(req & mine);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      busy <= 1'b0;
      remaining <= '0;
      heldRoute <= routerPkg::portLocal;
    end
    else if (head.pop)
    begin
      if (!busy)
      begin
        heldRoute <= newRoute;
        remaining <= hdr.length;
        busy <= (hdr.length != '0);
      end
      else
      begin
        remaining <= remaining - 1'b1;
        busy <= (remaining != `LENGTH_W'(1)); // Last body frees the route.
      end
    end
  end

endmodule

/* outputArbiter.sv */
`include "router_defines.svh"

module outputArbiter (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`NUM_PORTS-1:0] req,
  input  logic [`FLIT_ID_W-1:0] headFlitId [`NUM_PORTS],
  input  logic [`LENGTH_W-1:0]  headLength [`NUM_PORTS],
  output logic [`NUM_PORTS:0]   grant
);

  localparam logic [`NUM_PORTS:0] idle = 1;

  logic [`NUM_PORTS:0] nextGrant;
  logic [`NUM_PORTS-1:0] runTimer;
  logic [`NUM_PORTS-1:0] timesUp;

  for (genvar i = 0; i < `NUM_PORTS; i++)
  begin : timerGen
    packetTimer timer_inst (
      .clk     (clk),
      .rst     (rst),
      .flitId  (headFlitId[i]),
      .length  (headLength[i]),
      .run     (runTimer[i]),
      .timesUp (timesUp[i])
    );
  end

  always_comb
  begin : nextState
    int holder;
    int cand;
    holder = -1;
    cand = 0;
    nextGrant = idle;
    runTimer = '0;
    for (int i = 0; i < `NUM_PORTS; i++)
    begin
      if (grant[i + 1])
        holder = i;
    end
    if (holder < 0)
    begin
      // Fixed priority from idle, Local highest.
      for (int i = `NUM_PORTS - 1; i >= 0; i--)
      begin
        if (req[i])
          nextGrant = idle << (i + 1);
      end
    end
    else if (req[holder] && !timesUp[holder])
    begin
      runTimer[holder] = 1'b1; // Hold for the rest of the packet.
      nextGrant = grant;
    end
    else
    begin
      // Rotate, starting just after the holder.
      for (int k = `NUM_PORTS - 1; k >= 1; k--)
      begin
        cand = (holder + k) % `NUM_PORTS;
        if (req[cand])
          nextGrant = idle << (cand + 1);
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      grant <= idle;
    else
      grant <= nextGrant;
  end

  grantOneHot: assert property (@(posedge clk) disable iff (rst)
    $onehot(grant))
    else $error("outputArbiter: grant not one-hot");

endmodule

/* packetTimer.sv */
`include "router_defines.svh"

module packetTimer (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`FLIT_ID_W-1:0] flitId,
  input  logic [`LENGTH_W-1:0]  length,
  input  logic                  run,
  output logic                  timesUp
);

  logic [`LENGTH_W-1:0] limit;
  logic [`LENGTH_W-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      if (flitId == `FLIT_HEADER)
        limit <= length; // Latched while the header waits.
      count <= run ? count + 1'b1 : '0;
    end
  end

  // Counts 0 to length, so a grant spans length+1 cycles.
  assign timesUp = (count == limit);

endmodule

/* router.sv */
`include "router_defines.svh"

module router #(
  parameter int routerX = 0,
  parameter int routerY = 0
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [`FLIT_ID_W-1:0] inFlitId [`NUM_PORTS],
  input  logic [`PAYLOAD_W-1:0] inPayload [`NUM_PORTS],
  input  logic [`NUM_PORTS-1:0] inValid,
  output logic [`FLIT_ID_W-1:0] outFlitId [`NUM_PORTS],
  output logic [`PAYLOAD_W-1:0] outPayload [`NUM_PORTS],
  output logic [`NUM_PORTS-1:0] outValid
);

  flitLink link [`NUM_PORTS] ();

  logic [`NUM_PORTS-1:0] req [`NUM_PORTS];   // Indexed by input.
  logic [`NUM_PORTS-1:0] reqTo [`NUM_PORTS]; // Indexed by output.
  logic [`NUM_PORTS:0] grants [`NUM_PORTS];
  logic [`NUM_PORTS-1:0] pops;
  logic [`FLIT_ID_W-1:0] headFlitId [`NUM_PORTS];
  logic [`LENGTH_W-1:0] headLength [`NUM_PORTS];

  for (genvar p = 0; p < `NUM_PORTS; p++)
  begin : inGen
    flitFifo fifo_inst (
      .clk       (clk),
      .rst       (rst),
      .inFlitId  (inFlitId[p]),
      .inPayload (inPayload[p]),
      .inValid   (inValid[p]),
      .head      (link[p])
    );

    inputRoute #(
      .routerX (routerX),
      .routerY (routerY),
      .myPort  (routerPkg::portIdx'(p))
    ) route_inst (
      .clk    (clk),
      .rst    (rst),
      .head   (link[p]),
      .grants (grants),
      .req    (req[p])
    );

    assign pops[p] = link[p].pop;
    assign headFlitId[p] = link[p].flitId;
    assign headLength[p] = link[p].payload.header.length;
  end

  for (genvar o = 0; o < `NUM_PORTS; o++)
  begin : outGen
    for (genvar i = 0; i < `NUM_PORTS; i++)
    begin : reqGen
      assign reqTo[o][i] = req[i][o];
    end

    outputArbiter arb_inst (
      .clk        (clk),
      .rst        (rst),
      .req        (reqTo[o]),
      .headFlitId (headFlitId),
      .headLength (headLength),
      .grant      (grants[o])
    );
  end

  crossbar xbar_inst (
    .clk        (clk),
    .rst        (rst),
    .heads      (link),
    .pops       (pops),
    .grants     (grants),
    .outFlitId  (outFlitId),
    .outPayload (outPayload),
    .outValid   (outValid)
  );

endmodule

/* routerPkg.sv */
`include "router_defines.svh"

package routerPkg;

  // Port order doubles as arbitration priority from idle.
  typedef enum logic [2:0] {
    portLocal = 3'd0,
    portNorth = 3'd1,
    portEast  = 3'd2,
    portWest  = 3'd3,
    portSouth = 3'd4
  } portIdx;

  typedef struct packed {
    logic [`COORD_W-1:0] destX;
    logic [`COORD_W-1:0] destY;
    logic [`LENGTH_W-1:0] length; // Body flits after the header.
    logic [`PAYLOAD_W-2*`COORD_W-`LENGTH_W-1:0] pad;
  } headerFields;

  typedef union packed {
    headerFields header;
    logic [`PAYLOAD_W-1:0] data;
  } flitPayload;

endpackage

/* routerTests.svh */
`ifndef ROUTER_TESTS_SVH
`define ROUTER_TESTS_SVH

task automatic idleAfterReset();
  int errs;
  errs = errCount;
  repeat (20)
  begin
    @(negedge clk);
    checkEq("outValid", 32'(outValid), 32'h0);
  end
  reportTest("idle after reset", errs);
endtask

// One packet from Local to each direction in turn.
task automatic singleRoutes();
  int dx [5];
  int dy [5];
  int n;
  int errs;
  errs = errCount;
  dx = '{4, 2, 0, 2, 2}; // East, North, West, South, Local.
  dy = '{2, 4, 2, 0, 2};
  for (int t = 0; t < 5; t++)
  begin
    addPacket(0, dx[t], dy[t], t + 1, n);
    driveAll();
    waitDrained(100);
  end
  reportTest("single routes", errs);
endtask

task automatic sameOutputContention();
  int first;
  int second;
  int errs;
  errs = errCount;
  arrivals.delete();
  addPacket(0, 6, 1, 3, first); // Local to East.
  addPacket(3, 6, 1, 3, second); // West to East, same cycle.
  driveAll();
  waitDrained(100);
  checkEq("arrivals.size", arrivals.size(), 2);
  if (arrivals.size() == 2)
  begin
    checkEq("arrivals[0]", arrivals[0], first);
    checkEq("arrivals[1]", arrivals[1], second);
  end
  reportTest("same output contention", errs);
endtask

task automatic allPortsParallel();
  int n;
  int errs;
  errs = errCount;
  addPacket(0, 2, 3, 2, n); // To North.
  addPacket(1, 2, 0, 3, n); // To South.
  addPacket(2, 0, 2, 1, n); // To West.
  addPacket(3, 4, 2, 4, n); // To East.
  addPacket(4, 2, 2, 5, n); // To Local.
  driveAll();
  waitDrained(100);
  reportTest("all ports parallel", errs);
endtask

// Rounds keep each source within one FIFO of flits.
task automatic randomTraffic();
  int src;
  int dx;
  int dy;
  int len;
  int n;
  int errs;
  errs = errCount;
  for (int t = 0; t < 40; t++)
  begin
    src = int'($unsigned($random(seed)) % 5);
    dx = $random(seed) & 15;
    dy = $random(seed) & 15;
    len = int'($unsigned($random(seed)) % 7);
    if (srcFlits[src] + len + 1 > `FIFO_DEPTH)
    begin
      driveAll();
      waitDrained(400);
    end
    addPacket(src, dx, dy, len, n);
  end
  driveAll();
  waitDrained(400);
  reportTest("random traffic", errs);
endtask

`endif

/* routerTb.sv */
`include "router_defines.svh"

module routerTb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int hereX = 2;
  localparam int hereY = 2;
  localparam int maxPkts = 64;

  logic clk = 1'b0;
  logic rst;
  logic [`FLIT_ID_W-1:0] inFlitId [`NUM_PORTS];
  logic [`PAYLOAD_W-1:0] inPayload [`NUM_PORTS];
  logic [`NUM_PORTS-1:0] inValid;
  logic [`FLIT_ID_W-1:0] outFlitId [`NUM_PORTS];
  logic [`PAYLOAD_W-1:0] outPayload [`NUM_PORTS];
  logic [`NUM_PORTS-1:0] outValid;

  int seed;
  int errCount = 0;
  int passCount = 0;
  int failCount = 0;
  int sentFlits = 0;
  int expFlits = 0; // Flits still due at the outputs.
  int pktCount = 0;

  // Word 0 is the header payload.
  logic [`PAYLOAD_W-1:0] pktData [maxPkts][7];
  int pktSrc [maxPkts];
  int pktOut [maxPkts];
  int pktLen [maxPkts];
  int pendQ [$]; // Header not seen yet.
  int arrivals [$];
  int srcList [`NUM_PORTS][`FIFO_DEPTH];
  int srcCnt [`NUM_PORTS];
  int srcFlits [`NUM_PORTS];
  int curPkt [`NUM_PORTS]; // Packet in progress per output.
  int curBody [`NUM_PORTS];

  router #(
    .routerX (hereX),
    .routerY (hereY)
  ) router_inst (
    .clk        (clk),
    .rst        (rst),
    .inFlitId   (inFlitId),
    .inPayload  (inPayload),
    .inValid    (inValid),
    .outFlitId  (outFlitId),
    .outPayload (outPayload),
    .outValid   (outValid)
  );

  always
    #2 clk = ~clk;

  initial
  begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < sentFlits * 20 + 200)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles with %0d flits sent", cycles, sentFlits);
    $display("** FAIL **");
    $finish;
  end

  task automatic checkEq(string name, logic [31:0] got, logic [31:0] exp);
    assert (got === exp)
    else
    begin
      $display("CHECK FAILED %s got %h expected %h", name, got, exp);
      errCount++;
    end
  endtask

  task automatic noteError(string msg);
    $display("%s", msg);
    errCount++;
  endtask

  task automatic reportTest(string name, int errsBefore);
    if (errCount == errsBefore)
    begin
      passCount++;
      $display("Test %s: passed", name);
    end
    else
    begin
      failCount++;
      $display("Test %s: failed with %0d errors", name, errCount - errsBefore);
    end
  endtask

  // X first, then Y.
  function automatic int xyPort(int dx, int dy);
    if (dx > hereX)
      return int'(routerPkg::portEast);
    if (dx < hereX)
      return int'(routerPkg::portWest);
    if (dy > hereY)
      return int'(routerPkg::portNorth);
    if (dy < hereY)
      return int'(routerPkg::portSouth);
    return int'(routerPkg::portLocal);
  endfunction

  task automatic addPacket(input int src, input int dx, input int dy, input int len,
                           output int n);
    n = pktCount;
    pktCount++;
    pktSrc[n] = src;
    pktLen[n] = len;
    pktOut[n] = xyPort(dx, dy);
    pktData[n][0] = {4'(dx), 4'(dy), 12'(len), 12'(n)}; // Pad holds a unique tag.
    for (int b = 1; b <= len; b++)
      pktData[n][b] = $random(seed);
    srcList[src][srcCnt[src]] = n;
    srcCnt[src]++;
    srcFlits[src] += len + 1;
    expFlits += len + 1;
    pendQ.push_back(n);
  endtask

  // All sources start together, each back to back.
  task automatic driveAll();
    int pos [`NUM_PORTS];
    int fl [`NUM_PORTS];
    int k;
    bit active;
    pos = '{default: 0};
    fl = '{default: 0};
    do
    begin
      @(negedge clk);
      active = 1'b0;
      for (int p = 0; p < `NUM_PORTS; p++)
      begin
        inValid[p] = 1'b0;
        if (pos[p] < srcCnt[p])
        begin
          k = srcList[p][pos[p]];
          inValid[p] = 1'b1;
          inFlitId[p] = (fl[p] == 0) ? `FLIT_HEADER : `FLIT_BODY;
          inPayload[p] = pktData[k][fl[p]];
          sentFlits++;
          active = 1'b1;
          fl[p]++;
          if (fl[p] > pktLen[k])
          begin
            fl[p] = 0;
            pos[p]++;
          end
        end
      end
    end
    while (active);
    srcCnt = '{default: 0};
    srcFlits = '{default: 0};
  endtask

  task automatic waitDrained(int limit);
    int n;
    n = 0;
    while (expFlits > 0 && n < limit)
    begin
      @(posedge clk);
      n++;
    end
    assert (expFlits == 0 && pendQ.size() == 0)
    else noteError($sformatf("Outputs still owe %0d flits of %0d packets after %0d cycles",
                             expFlits, pendQ.size(), n));
  endtask

  task automatic takeFlit(int o);
    int k;
    int hit;
    expFlits--;
    k = curPkt[o];
    if (k >= 0)
    begin
      checkEq($sformatf("outFlitId[%0d]", o), 32'(outFlitId[o]), 32'(`FLIT_BODY));
      checkEq($sformatf("outPayload[%0d]", o), outPayload[o], pktData[k][curBody[o]]);
      curBody[o]++;
      if (curBody[o] > pktLen[k])
        curPkt[o] = -1;
    end
    else
    begin
      hit = -1;
      for (int q = pendQ.size() - 1; q >= 0; q--)
      begin
        if (pktData[pendQ[q]][0] == outPayload[o])
          hit = q;
      end
      checkEq($sformatf("outFlitId[%0d]", o), 32'(outFlitId[o]), 32'(`FLIT_HEADER));
      assert (hit >= 0)
      else noteError($sformatf("Output %0d sent a header that no packet expects", o));
      if (hit >= 0)
      begin
        k = pendQ[hit];
        checkEq($sformatf("output port of packet %0d", k), o, pktOut[k]);
        for (int q = 0; q < hit; q++)
        begin
          assert (pktSrc[pendQ[q]] != pktSrc[k] || pktOut[pendQ[q]] != o)
          else noteError($sformatf("Packet %0d overtook packet %0d of the same source",
                                   k, pendQ[q]));
        end
        pendQ.delete(hit);
        arrivals.push_back(k);
        if (pktLen[k] > 0)
        begin
          curPkt[o] = k;
          curBody[o] = 1;
        end
      end
    end
  endtask

  // Outputs only move on the rising edge.
  always @(negedge clk)
  begin
    for (int o = 0; o < `NUM_PORTS; o++)
    begin
      if (outValid[o])
        takeFlit(o);
    end
  end

  `include "routerTests.svh"

  initial
  begin
    seed = 32'h9e8c_a7f8;
    rst = 1'b1;
    inValid = '0;
    for (int p = 0; p < `NUM_PORTS; p++)
    begin
      inFlitId[p] = '0;
      inPayload[p] = '0;
    end
    srcCnt = '{default: 0};
    srcFlits = '{default: 0};
    curPkt = '{default: -1};
    curBody = '{default: 0};
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    idleAfterReset();
    singleRoutes();
    sameOutputContention();
    allPortsParallel();
    randomTraffic();
    $display("Tests passed %0d, failed %0d, check errors %0d", passCount, failCount, errCount);
    if (errCount == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

/* router_defines.svh */
`ifndef ROUTER_DEFINES_SVH
`define ROUTER_DEFINES_SVH

// Flit identifier.
`define FLIT_ID_W 3
`define FLIT_HEADER 3'b001
`define FLIT_BODY 3'b010

// Flit payload and header fields.
`define PAYLOAD_W 32
`define LENGTH_W 12
`define COORD_W 4

// Router geometry.
`define FIFO_DEPTH 8
`define NUM_PORTS 5

`endif

/* run.sh */
#!/bin/sh
# Build and run the router testbench, pass only on the pass line.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module routerTb -f verilog.f -o routerSim &&
./obj_dir/routerSim | tee /dev/stderr | grep -qx '\*\* PASS \*\*' &&
echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

/* verilog.f */
+incdir+.
routerPkg.sv
flitLink.sv
flitFifo.sv
inputRoute.sv
packetTimer.sv
outputArbiter.sv
crossbar.sv
router.sv
routerTb.sv
